// ==== audio_out_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_out_top (
   input  wire                     clk,
   input  wire                     mrst_n,
   // CPU bus
   input  wire [7:0]               addr,
   input  wire                     iorq_n,
   input  wire                     rd_n,
   input  wire                     wr_n,
   input  wire audio_pkg::pan_t    din,
   output wire audio_pkg::pan_t    dout,
   output wire                     oe_n,
   // Sound sources
   input  wire                     ear,
   input  wire                     spk,
   input  wire                     mic,
   input  wire audio_pkg::src_t    psg1_a,
   input  wire audio_pkg::src_t    psg1_b,
   input  wire audio_pkg::src_t    psg1_c,
   input  wire audio_pkg::src_t    psg2_a,
   input  wire audio_pkg::src_t    psg2_b,
   input  wire audio_pkg::src_t    psg2_c,
   input  wire audio_pkg::src_t    drum,
   // 1-bit streams
   output wire                     audio_left,
   output wire                     audio_right
);

   import audio_pkg::*;

   wire pan_t    pan;
   wire sample_t left_sample;
   wire sample_t right_sample;
   wire          sample_valid;   // Frame strobe to both modulators

   ////////////////////////////////////////////////////////////////////////////
   // Port F7 and mixer

   pan_port u_pan_port (
      .clk    (clk),
      .mrst_n (mrst_n),
      .addr   (addr),
      .iorq_n (iorq_n),
      .rd_n   (rd_n),
      .wr_n   (wr_n),
      .din    (din),
      .dout   (dout),
      .oe_n   (oe_n),
      .pan    (pan)
   );

   stereo_mixer u_mixer (
      .clk          (clk),
      .mrst_n       (mrst_n),
      .pan          (pan),
      .ear          (ear),
      .spk          (spk),
      .mic          (mic),
      .psg1_a       (psg1_a),
      .psg1_b       (psg1_b),
      .psg1_c       (psg1_c),
      .psg2_a       (psg2_a),
      .psg2_b       (psg2_b),
      .psg2_c       (psg2_c),
      .drum         (drum),
      .left_sample  (left_sample),
      .right_sample (right_sample),
      .sample_valid (sample_valid)
   );

   ////////////////////////////////////////////////////////////////////////////
   // One modulator per speaker

   sigma_delta_dac u_dac_left (
      .clk    (clk),
      .mrst_n (mrst_n),
      .sample (left_sample),
      .load   (sample_valid),
      .pdm    (audio_left)
   );

   sigma_delta_dac u_dac_right (
      .clk    (clk),
      .mrst_n (mrst_n),
      .sample (right_sample),
      .load   (sample_valid),
      .pdm    (audio_right)
   );

endmodule

`default_nettype wire

// ==== audio_pkg.sv ====
`default_nettype none

package audio_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths and payload types

   localparam int SRC_W    = 8;    // One source level
   localparam int SAMPLE_W = 9;    // Mixed sample, 0..511
   localparam int ACC_W    = 12;   // Mixing accumulator, signed during rescale
   localparam int SIGMA_W  = SAMPLE_W + 2;  // Modulator integrator

   typedef logic [SRC_W-1:0]    src_t;
   typedef logic [SAMPLE_W-1:0] sample_t;
   typedef logic [7:0]          pan_t;   // A l/r, B l/r, C l/r, beeper+drum l/r

   ////////////////////////////////////////////////////////////////////////////
   // CPU port

   localparam logic [7:0] PAN_ADDR  = 8'hF7;
   localparam pan_t       PAN_RESET = 8'h9F;   // ACB stereo, beeper+drum on both

   ////////////////////////////////////////////////////////////////////////////
   // Mixing frame

   localparam int FRAME_LEN  = 11;     // Cycles per mix frame
   localparam int MIX_BIAS   = 1024;   // Subtracted before the divide by 4
   localparam int SAMPLE_MID = 256;    // Re-centres the scaled sum

   // Beeper level, index is {ear, spk, mic}
   localparam src_t BEEPER_LEVEL [0:7] = '{
      8'd17, 8'd36, 8'd184, 8'd192, 8'd22, 8'd48, 8'd244, 8'd255
   };

endpackage

`default_nettype wire

// ==== audio_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_properties (
   input  wire                      clk,
   input  wire                      mrst_n,
   input  wire [7:0]                addr,
   input  wire                      iorq_n,
   input  wire                      rd_n,
   input  wire                      oe_n,
   input  wire                      sample_valid,
   input  wire audio_pkg::sample_t  left_sample,
   input  wire audio_pkg::sample_t  right_sample,
   input  wire                      audio_left,
   input  wire                      audio_right
);

   import audio_pkg::*;

   logic [3:0] gap;    // Cycles since the last valid pulse
   logic       seen;   // At least one pulse since reset

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         gap  <= 4'd0;
         seen <= 1'b0;
      end else if (sample_valid) begin
         gap  <= 4'd0;
         seen <= 1'b1;
      end else if (gap != 4'hF) begin
         gap <= gap + 4'd1;   // Saturates, no wrap
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus, frame and reset properties

   oe_decode: assert property (@(posedge clk)
      oe_n == !((addr == PAN_ADDR) && !iorq_n && !rd_n))
      else $error("oe_n does not match the decoded read of port F7");

   valid_spacing: assert property (@(posedge clk) disable iff (!mrst_n)
      seen |-> (sample_valid == (gap == 4'(FRAME_LEN - 1))))
      else $error("sample_valid spacing differs from one frame");

   reset_state: assert property (@(posedge clk)
      !mrst_n |=> (!audio_left && !audio_right && !sample_valid))
      else $error("Outputs not cleared in the cycle after reset");

   sample_range: assert property (@(posedge clk) disable iff (!mrst_n)
      sample_valid |-> ((left_sample <= 9'd510) && (right_sample <= 9'd510)))
      else $error("Mixed sample above 510");

endmodule

bind audio_out_top audio_properties u_audio_properties (
   .clk          (clk),
   .mrst_n       (mrst_n),
   .addr         (addr),
   .iorq_n       (iorq_n),
   .rd_n         (rd_n),
   .oe_n         (oe_n),
   .sample_valid (sample_valid),
   .left_sample  (left_sample),
   .right_sample (right_sample),
   .audio_left   (audio_left),
   .audio_right  (audio_right)
);

`default_nettype wire

// ==== audio_stimulus.txt ====
# name pan(hex) psg1_a psg1_b psg1_c psg2_a psg2_b psg2_c drum ear spk mic exp_l exp_r rd(hex)
# Levels decimal, expected sample = 256 + floor((routed sum - 1024) / 4)
mute_all      00 100 100 100 100 100 100  50 0 0 0   0   0 00
left_only     AA 200 150 100  50  60  70  30 0 1 1 213   0 AA
right_only    55 200 150 100  50  60  70  30 0 1 1   0 213 55
split_groups  96 120  40  64  80  20  64 100 1 0 0  80  47 96
full_scale    FF 255 255 255 255 255 255 255 1 1 1 510 510 FF
all_zero      FC   0   0   0   0   0   0   0 0 0 0   0   0 FC
mid_scale     CC 255 200 255 255 200 255 200 1 1 1 255 255 CC
beeper_000    03  77  77  77  77  77  77   0 0 0 0   4   4 03
beeper_001    03  77  77  77  77  77  77   0 0 0 1   9   9 03
beeper_010    03  77  77  77  77  77  77   0 0 1 0  46  46 03
beeper_011    03  77  77  77  77  77  77   0 0 1 1  48  48 03
beeper_100    03  77  77  77  77  77  77   0 1 0 0   5   5 03
beeper_101    03  77  77  77  77  77  77   0 1 0 1  12  12 03
beeper_110    03  77  77  77  77  77  77   0 1 1 0  61  61 03
beeper_111    03  77  77  77  77  77  77   0 1 1 1  63  63 03
b_and_beeper  33 255 128 255 255 128 255 255 1 1 1 191 191 33

// ==== build.f ====
audio_pkg.sv
pan_port.sv
stereo_mixer.sv
sigma_delta_dac.sv
audio_out_top.sv
audio_properties.sv
tb_audio_out.sv

// ==== pan_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module pan_port (
   input  wire                     clk,
   input  wire                     mrst_n,
   input  wire [7:0]               addr,
   input  wire                     iorq_n,
   input  wire                     rd_n,
   input  wire                     wr_n,
   input  wire audio_pkg::pan_t    din,
   output audio_pkg::pan_t         dout,
   output logic                    oe_n,
   output audio_pkg::pan_t         pan
);

   import audio_pkg::*;

   logic   addr_hit;   // Port F7 selected
   logic   wr_stb;
   pan_t   pan_q;

   // Address decode shared by both strobes
   assign addr_hit = (addr == PAN_ADDR) && !iorq_n;
   assign wr_stb   = addr_hit && !wr_n;

   // Panning register
   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         pan_q <= PAN_RESET;
      end else if (wr_stb) begin
         pan_q <= din;   // Taken on the strobe edge
      end
   end

   // Read side is purely combinational
   assign oe_n = !(addr_hit && !rd_n);
   assign dout = pan_q;   // Always visible and qualified by oe_n

   assign pan = pan_q;    // Routing byte to the mixer

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stereo audio output testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_audio_out -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build returned status $status"
   exit $status
fi

./obj_dir/Vtb_audio_out
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation returned status $status"
fi
exit $status

// ==== sigma_delta_dac.sv ====
`timescale 1ns/1ns
`default_nettype none

module sigma_delta_dac (
   input  wire                      clk,
   input  wire                      mrst_n,
   input  wire audio_pkg::sample_t  sample,
   input  wire                      load,
   output logic                     pdm
);

   import audio_pkg::*;

   sample_t            held;        // Last accepted sample
   sample_t            cur;
   logic [SIGMA_W-1:0] delta_fb;    // Feedback from the integrator top bit
   logic [SIGMA_W-1:0] sigma;
   logic [SIGMA_W-1:0] sigma_nxt;

   // New sample counts from the load edge on
   assign cur = load ? sample : held;

   // Top bit set means subtract full scale
   assign delta_fb  = {sigma[SIGMA_W-1], sigma[SIGMA_W-1], {SAMPLE_W{1'b0}}};
   assign sigma_nxt = sigma + delta_fb + SIGMA_W'(cur);

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         held  <= '0;
         sigma <= SIGMA_W'(1) << (SIGMA_W - 2);   // Mid-scale
         pdm   <= 1'b0;
      end else begin
         if (load) begin
            held <= sample;
         end
         sigma <= sigma_nxt;
         pdm   <= sigma[SIGMA_W-1];   // Registered pulse stream
      end
   end

endmodule

`default_nettype wire

// ==== stereo_mixer.sv ====
`timescale 1ns/1ns
`default_nettype none

module stereo_mixer (
   input  wire                       clk,
   input  wire                       mrst_n,
   input  wire audio_pkg::pan_t      pan,
   input  wire                       ear,
   input  wire                       spk,
   input  wire                       mic,
   input  wire audio_pkg::src_t      psg1_a,
   input  wire audio_pkg::src_t      psg1_b,
   input  wire audio_pkg::src_t      psg1_c,
   input  wire audio_pkg::src_t      psg2_a,
   input  wire audio_pkg::src_t      psg2_b,
   input  wire audio_pkg::src_t      psg2_c,
   input  wire audio_pkg::src_t      drum,
   output audio_pkg::sample_t        left_sample,
   output audio_pkg::sample_t        right_sample,
   output logic                      sample_valid
);

   import audio_pkg::*;

   localparam logic [3:0] LAST_STATE = 4'(FRAME_LEN - 1);

   logic [3:0]       state;        // Frame step 0..FRAME_LEN-1
   logic             frame_seen;   // One full frame done since reset
   src_t             beeper;
   logic [ACC_W-1:0] pair_a;
   logic [ACC_W-1:0] pair_b;
   logic [ACC_W-1:0] pair_c;
   logic [ACC_W-1:0] pair_d;
   logic [ACC_W-1:0] acc_l;
   logic [ACC_W-1:0] acc_r;

   ////////////////////////////////////////////////////////////////////////////
   // Group sums of two sources each

   assign beeper = BEEPER_LEVEL[{ear, spk, mic}];

   assign pair_a = ACC_W'(psg1_a) + ACC_W'(psg2_a);
   assign pair_b = ACC_W'(psg1_b) + ACC_W'(psg2_b);
   assign pair_c = ACC_W'(psg1_c) + ACC_W'(psg2_c);
   assign pair_d = ACC_W'(beeper) + ACC_W'(drum);   // Beeper plus drum DAC

   ////////////////////////////////////////////////////////////////////////////
   // Frame sequencer

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         state        <= 4'd0;
         frame_seen   <= 1'b0;
         sample_valid <= 1'b0;
      end else begin
         state        <= (state == LAST_STATE) ? 4'd0 : state + 4'd1;
         sample_valid <= (state == 4'd0) && frame_seen;   // One pulse per frame
         if (state == LAST_STATE) begin
            frame_seen <= 1'b1;
         end
      end
   end

   // Accumulators stepped by the frame state
   always_ff @(posedge clk) begin
      case (state)
         4'd0: begin
            if (frame_seen) begin   // Last frame's results out
               left_sample  <= acc_l[SAMPLE_W-1:0];
               right_sample <= acc_r[SAMPLE_W-1:0];
            end
            acc_l <= pan[7] ? pair_a : '0;   // A left
         end
         4'd1: acc_r <= pan[6] ? pair_a : '0;   // A right
         4'd2: if (pan[5]) acc_l <= acc_l + pair_b;
         4'd3: if (pan[4]) acc_r <= acc_r + pair_b;
         4'd4: if (pan[3]) acc_l <= acc_l + pair_c;
         4'd5: if (pan[2]) acc_r <= acc_r + pair_c;
         4'd6: if (pan[1]) acc_l <= acc_l + pair_d;   // Beeper+drum left
         4'd7: if (pan[0]) acc_r <= acc_r + pair_d;   // Beeper+drum right on bit 0
         4'd8: begin
            // Remove bias so the sum may go negative
            acc_l <= acc_l - ACC_W'(MIX_BIAS);
            acc_r <= acc_r - ACC_W'(MIX_BIAS);
         end
         4'd9: begin
            // Signed floor divide by 4
            acc_l <= {{2{acc_l[ACC_W-1]}}, acc_l[ACC_W-1:2]};
            acc_r <= {{2{acc_r[ACC_W-1]}}, acc_r[ACC_W-1:2]};
         end
         4'd10: begin
            acc_l <= acc_l + ACC_W'(SAMPLE_MID);   // Back to 0..510
            acc_r <= acc_r + ACC_W'(SAMPLE_MID);
         end
         default: begin
            acc_l <= acc_l;
            acc_r <= acc_r;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== tb_audio_out.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_audio_out;

   import audio_pkg::*;

   localparam int SETTLE_CYC   = 23 + 64;   // Propagation plus modulator settling
   localparam int WINDOW_CYC   = 512;       // Density window
   localparam int CYC_PER_TEST = 700;
   localparam int CYC_EXTRA    = 200;

   typedef logic [8*24-1:0] name_t;

   typedef struct packed {
      name_t   name;
      pan_t    pan;
      src_t    psg1_a;
      src_t    psg1_b;
      src_t    psg1_c;
      src_t    psg2_a;
      src_t    psg2_b;
      src_t    psg2_c;
      src_t    drum;
      logic    ear;
      logic    spk;
      logic    mic;
      sample_t exp_l;
      sample_t exp_r;
      pan_t    exp_rd;
   } test_t;

   localparam name_t RESET_NAME  = name_t'("reset_readback");
   localparam name_t MIDRUN_NAME = name_t'("midrun_reset");

   logic       clk;
   logic       mrst_n;
   logic [7:0] addr;
   logic       iorq_n;
   logic       rd_n;
   logic       wr_n;
   pan_t       din;
   pan_t       dout;
   logic       oe_n;
   logic       ear;
   logic       spk;
   logic       mic;
   src_t       psg1_a;
   src_t       psg1_b;
   src_t       psg1_c;
   src_t       psg2_a;
   src_t       psg2_b;
   src_t       psg2_c;
   src_t       drum;
   logic       audio_left;
   logic       audio_right;

   test_t tests[$];
   int    cycles = 0;
   int    cycle_limit = 0;   // Zero until the stimulus is loaded

   audio_out_top i_audio_out_top (
      .clk         (clk),
      .mrst_n      (mrst_n),
      .addr        (addr),
      .iorq_n      (iorq_n),
      .rd_n        (rd_n),
      .wr_n        (wr_n),
      .din         (din),
      .dout        (dout),
      .oe_n        (oe_n),
      .ear         (ear),
      .spk         (spk),
      .mic         (mic),
      .psg1_a      (psg1_a),
      .psg1_b      (psg1_b),
      .psg1_c      (psg1_c),
      .psg2_a      (psg2_a),
      .psg2_b      (psg2_b),
      .psg2_c      (psg2_c),
      .drum        (drum),
      .audio_left  (audio_left),
      .audio_right (audio_right)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   // Watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("sim failed");
         $fatal(1, "Watchdog expired");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_pan(input name_t name, input pan_t exp, input pan_t act);
      if (act !== exp) begin
         fail_run($sformatf("ERROR %0s readback: expected %02h, actual %02h", name, exp, act));
      end
   endtask

   task automatic check_flag(input name_t name, input logic exp, input logic act);
      if (act !== exp) begin
         fail_run($sformatf("ERROR %0s oe_n: expected %0b, actual %0b", name, exp, act));
      end
   endtask

   // Pulse count may differ from the sample by one
   task automatic check_sample(input name_t name, input string side, input sample_t exp,
                               input sample_t act);
      int diff;
      diff = int'(act) - int'(exp);
      if (diff > 1 || diff < -1) begin
         fail_run($sformatf("ERROR %0s %0s: expected %0d, actual %0d", name, side, exp, act));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus and source drivers

   function automatic logic [7:0] idle_addr();
      logic [7:0] a;
      a = 8'($urandom());
      if (a == PAN_ADDR) begin
         a = a ^ 8'h01;   // Never the panning port
      end
      return a;
   endfunction

   task automatic bus_idle();
      addr   <= idle_addr();
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
   endtask

   task automatic bus_write(input name_t name, input pan_t value);
      @(posedge clk);
      addr   <= PAN_ADDR;
      iorq_n <= 1'b0;
      wr_n   <= 1'b0;
      rd_n   <= 1'b1;
      din    <= value;
      @(negedge clk);
      check_flag(name, 1'b1, oe_n);   // No read enable during a write
      @(posedge clk);                 // Register takes din here
      bus_idle();
   endtask

   task automatic bus_read(input logic [7:0] a, output pan_t data, output logic enable);
      @(posedge clk);
      addr   <= a;
      iorq_n <= 1'b0;
      rd_n   <= 1'b0;
      wr_n   <= 1'b1;
      @(negedge clk);
      data   = dout;
      enable = oe_n;
      @(posedge clk);
      bus_idle();
   endtask

   task automatic apply_sources(input test_t t);
      @(posedge clk);
      psg1_a <= t.psg1_a;
      psg1_b <= t.psg1_b;
      psg1_c <= t.psg1_c;
      psg2_a <= t.psg2_a;
      psg2_b <= t.psg2_b;
      psg2_c <= t.psg2_c;
      drum   <= t.drum;
      ear    <= t.ear;
      spk    <= t.spk;
      mic    <= t.mic;
   endtask

   task automatic count_ones(output int ones_l, output int ones_r);
      ones_l = 0;
      ones_r = 0;
      repeat (WINDOW_CYC) begin
         @(negedge clk);   // Stable half of the cycle
         if (audio_left) ones_l++;
         if (audio_right) ones_r++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus file and test sequence

   task automatic load_stimulus();
      int    fd;
      int    n;
      string line;
      name_t nm;
      int    pan_v, a1, b1, c1, a2, b2, c2, dr, e, s, m, xl, xr, rd;
      test_t t;
      fd = $fopen("audio_stimulus.txt", "r");
      if (fd == 0) begin
         fail_run("Cannot open audio_stimulus.txt");
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line.getc(0) != "#") begin   // Skip comments, blanks
            n = $sscanf(line, "%s %h %d %d %d %d %d %d %d %d %d %d %d %d %h", nm, pan_v,
                        a1, b1, c1, a2, b2, c2, dr, e, s, m, xl, xr, rd);
            if (n != 15) begin
               fail_run({"Malformed stimulus line: ", line});
            end
            t.name   = nm;
            t.pan    = pan_t'(pan_v);
            t.psg1_a = src_t'(a1);
            t.psg1_b = src_t'(b1);
            t.psg1_c = src_t'(c1);
            t.psg2_a = src_t'(a2);
            t.psg2_b = src_t'(b2);
            t.psg2_c = src_t'(c2);
            t.drum   = src_t'(dr);
            t.ear    = e[0];
            t.spk    = s[0];
            t.mic    = m[0];
            t.exp_l  = sample_t'(xl);
            t.exp_r  = sample_t'(xr);
            t.exp_rd = pan_t'(rd);
            tests.push_back(t);
         end
      end
      $fclose(fd);
      if (tests.size() == 0) begin
         fail_run("No tests found in audio_stimulus.txt");
      end
   endtask

   task automatic run_test(input test_t t);
      pan_t rd_data;
      logic rd_en;
      int   ones_l;
      int   ones_r;
      apply_sources(t);
      bus_write(t.name, t.pan);
      bus_read(PAN_ADDR, rd_data, rd_en);
      check_flag(t.name, 1'b0, rd_en);
      check_pan(t.name, t.exp_rd, rd_data);
      repeat (SETTLE_CYC) @(posedge clk);
      count_ones(ones_l, ones_r);
      if (ones_l > 511 || ones_r > 511) begin
         fail_run("A stream held more ones than any 9-bit sample can give");
      end
      check_sample(t.name, "left", t.exp_l, sample_t'(ones_l));
      check_sample(t.name, "right", t.exp_r, sample_t'(ones_r));
   endtask

   initial begin
      pan_t rd_data;
      logic rd_en;
      void'($urandom(32'h151f));
      mrst_n = 1'b0;
      addr   = 8'h00;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
      din    = '0;
      ear    = 1'b0;
      spk    = 1'b0;
      mic    = 1'b0;
      psg1_a = '0;
      psg1_b = '0;
      psg1_c = '0;
      psg2_a = '0;
      psg2_b = '0;
      psg2_c = '0;
      drum   = '0;
      load_stimulus();
      cycle_limit = tests.size() * CYC_PER_TEST + CYC_EXTRA;
      repeat (4) @(posedge clk);
      mrst_n <= 1'b1;

      // Reset value, and no enable for other addresses
      bus_read(PAN_ADDR, rd_data, rd_en);
      check_flag(RESET_NAME, 1'b0, rd_en);
      check_pan(RESET_NAME, PAN_RESET, rd_data);
      bus_read(idle_addr(), rd_data, rd_en);
      check_flag(RESET_NAME, 1'b1, rd_en);

      foreach (tests[i]) begin
         run_test(tests[i]);
      end

      // Last test still playing, reset under way
      @(posedge clk);
      mrst_n <= 1'b0;
      repeat (4) @(posedge clk);
      mrst_n <= 1'b1;
      bus_read(PAN_ADDR, rd_data, rd_en);
      check_flag(MIDRUN_NAME, 1'b0, rd_en);
      check_pan(MIDRUN_NAME, PAN_RESET, rd_data);

      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire
